// File: hdl/matmul_pkg.sv
`default_nettype none

package matmul_pkg;

  // bits per matrix element
  localparam int data_width = 8;

  // grid edge, also the lane count of a memory word
  localparam int array_size = 4;

  // pe input to accumulator update
  localparam int mac_stages = 2;

  // compute cycle on which the drain samples the grid
  localparam int drain_cycle = array_size           // words fed per bank
                             + 1                    // memory read
                             + (array_size - 1)     // deepest lane skew
                             + 2 * (array_size - 1) // hops to the far corner
                             + mac_stages
                             + 1;                   // margin

  // one signed matrix element
  typedef logic signed [data_width-1:0] elem_t;

  // memory word, stored flat and split into lanes
  // lane k sits in bits [k*data_width +: data_width]
  typedef union packed {
    logic [array_size*data_width-1:0] flat;
    elem_t [array_size-1:0]           lanes;
  } mem_word_u;

endpackage

`default_nettype wire

// File: hdl/matmul_top.sv
`default_nettype none

module matmul_top #(
  parameter int addr_width = 4
) (
  input  wire                                                      clk,
  input  wire                                                      reset,
  // host load port, shared by both operand memories
  input  wire                                                      we_a,
  input  wire                                                      we_b,
  input  wire [addr_width-1:0]                                     addr,
  input  wire [matmul_pkg::array_size*matmul_pkg::data_width-1:0]  wr_data,
  // level protocol
  input  wire                                                      start_mat_mul,
  // host read port for result rows
  input  wire                                                      rd_en,
  input  wire [addr_width-1:0]                                     rd_addr,
  output logic [matmul_pkg::array_size*matmul_pkg::data_width-1:0] rd_data,
  output logic                                                     done_mat_mul
);

  // skewed operand streams into the grid
  matmul_pkg::mem_word_u a_lanes;
  matmul_pkg::mem_word_u b_lanes;
  // all grid accumulators
  matmul_pkg::elem_t [matmul_pkg::array_size*matmul_pkg::array_size-1:0] sums;
  logic acc_clear;

  // A bank, word t is column t of A
  operand_bank #(
    .addr_width (addr_width)
  ) u_bank_a (
    .clk           (clk),
    .reset         (reset),
    .we            (we_a),
    .addr          (addr),
    .wr_data       (wr_data),
    .start_mat_mul (start_mat_mul),
    .lanes         (a_lanes)
  );

  // B bank, word t is row t of B
  operand_bank #(
    .addr_width (addr_width)
  ) u_bank_b (
    .clk           (clk),
    .reset         (reset),
    .we            (we_b),
    .addr          (addr),
    .wr_data       (wr_data),
    .start_mat_mul (start_mat_mul),
    .lanes         (b_lanes)
  );

  systolic_array u_array (
    .clk       (clk),
    .reset     (reset),
    .acc_clear (acc_clear),
    .a_lanes   (a_lanes),
    .b_lanes   (b_lanes),
    .sums      (sums)
  );

  // sequencing, result memory and read-back
  result_drain #(
    .addr_width (addr_width)
  ) u_drain (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .sums          (sums),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .acc_clear     (acc_clear),
    .rd_data       (rd_data),
    .done_mat_mul  (done_mat_mul)
  );

endmodule

`default_nettype wire

// File: hdl/operand_bank.sv
`default_nettype none

module operand_bank
  import matmul_pkg::*;
#(
  parameter int addr_width = 4
) (
  input  wire                             clk,
  input  wire                             reset,
  // host write port
  input  wire                             we,
  input  wire [addr_width-1:0]            addr,
  input  wire [array_size*data_width-1:0] wr_data,
  // level, held high for the whole run
  input  wire                             start_mat_mul,
  // skewed lanes toward one grid edge
  output mem_word_u                       lanes
);

  localparam int feed_w = $clog2(array_size + 1);
  // counter parks here once all words are read
  localparam logic [feed_w-1:0] feed_end = feed_w'(array_size);

  // operand words, one column of A or one row of B each
  logic [array_size*data_width-1:0] mem [2**addr_width];

  logic [feed_w-1:0]                feed_cnt;
  logic [addr_width-1:0]            feed_addr;
  logic [array_size*data_width-1:0] rd_word;
  logic                             word_valid;
  mem_word_u                        word_gated;
  // per lane output after its delay line
  elem_t                            skewed [array_size];

  // host writes land here while idle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wr_data;
    end
  end

  // walks words 0..array_size-1 from the first start edge
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      feed_cnt <= '0;
    end else if (feed_cnt != feed_end) begin
      feed_cnt <= feed_cnt + 1'b1;
    end
  end

  assign feed_addr = addr_width'(feed_cnt);

  // registered read, data one cycle behind the address
  always_ff @(posedge clk) begin
    rd_word <= mem[feed_addr];
  end

  // high while rd_word holds a fed word
  always_ff @(posedge clk) begin
    if (reset) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= start_mat_mul && (feed_cnt != feed_end);
    end
  end

  // zeros outside the feed window keep the grid quiet
  always_comb begin
    word_gated.flat = word_valid ? rd_word : '0;
  end

  // lane k delayed k cycles for the wavefront
  generate
    for (genvar k = 0; k < array_size; k++) begin : g_lane
      if (k == 0) begin : g_direct
        assign skewed[k] = word_gated.lanes[k];
      end else begin : g_delay
        elem_t dly [k];

        // cleared between runs so no stale data leaks in
        always_ff @(posedge clk) begin
          if (reset || !start_mat_mul) begin
            for (int d = 0; d < k; d++) begin
              dly[d] <= '0;
            end
          end else begin
            dly[0] <= word_gated.lanes[k];
            for (int d = 1; d < k; d++) begin
              dly[d] <= dly[d-1];
            end
          end
        end

        assign skewed[k] = dly[k-1];
      end
    end
  endgenerate

  // repack the lanes into one word
  always_comb begin
    for (int k = 0; k < array_size; k++) begin
      lanes.lanes[k] = skewed[k];
    end
  end

endmodule

`default_nettype wire

// File: hdl/processing_element.sv
`default_nettype none

module processing_element
  import matmul_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  // zeroes the mac between runs
  input  wire        acc_clear,
  input  wire elem_t in_a,
  input  wire elem_t in_b,
  // operands forwarded east and south
  output elem_t      out_a,
  output elem_t      out_b,
  output elem_t      acc
);

  localparam int prod_w = 2 * data_width;
  // int8 saturation bounds in product width
  localparam logic signed [prod_w-1:0] sat_max = prod_w'(2 ** (data_width - 1) - 1);
  localparam logic signed [prod_w-1:0] sat_min = prod_w'(-(2 ** (data_width - 1)));

  logic signed [prod_w-1:0] full_prod;
  elem_t                    clamped;
  elem_t                    prod;

  // full signed product
  assign full_prod = in_a * in_b;

  // clamp to the element range
  always_comb begin
    if (full_prod > sat_max) begin
      clamped = elem_t'(sat_max);
    end else if (full_prod < sat_min) begin
      clamped = elem_t'(sat_min);
    end else begin
      clamped = elem_t'(full_prod);
    end
  end

  // one hop per cycle to the neighbours
  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // product stage, then accumulate
  // the 8 bit sum wraps on overflow
  always_ff @(posedge clk) begin
    if (reset || acc_clear) begin
      prod <= '0;
      acc  <= '0;
    end else begin
      prod <= clamped;
      acc  <= acc + prod;
    end
  end

endmodule

`default_nettype wire

// File: hdl/result_drain.sv
`default_nettype none

module result_drain
  import matmul_pkg::*;
#(
  parameter int addr_width = 4
) (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   start_mat_mul,
  // grid accumulators, row major
  input  wire elem_t [array_size*array_size-1:0] sums,
  // host read port
  input  wire                                   rd_en,
  input  wire [addr_width-1:0]                  rd_addr,
  output logic                                  acc_clear,
  output logic [array_size*data_width-1:0]      rd_data,
  output logic                                  done_mat_mul
);

  localparam int word_width = array_size * data_width;
  // one cycle after the last row write
  localparam int done_cycle = drain_cycle + array_size + 1;
  localparam int cnt_w      = $clog2(done_cycle + 1);
  localparam int row_w      = $clog2(array_size);

  localparam logic [cnt_w-1:0] latch_at = cnt_w'(drain_cycle);
  localparam logic [cnt_w-1:0] wr_last  = cnt_w'(drain_cycle + array_size - 1);
  localparam logic [cnt_w-1:0] done_at  = cnt_w'(done_cycle);

  // result rows, row i of C at address i
  logic [word_width-1:0] res_mem [2**addr_width];

  logic [cnt_w-1:0]                   cnt;
  logic                               wr_en;
  logic [row_w-1:0]                   wr_row;
  elem_t [array_size*array_size-1:0]  sums_q;
  mem_word_u                          row_word;
  logic [word_width-1:0]              rd_word;
  logic                               rd_pend;

  // counts compute cycles, parks at done
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      cnt <= '0;
    end else if (cnt != done_at) begin
      cnt <= cnt + 1'b1;
    end
  end

  // idle means accumulators held at zero
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_clear <= 1'b0;
    end else begin
      acc_clear <= !start_mat_mul;
    end
  end

  // write window, one row per cycle after the latch
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= start_mat_mul && (cnt >= latch_at) && (cnt <= wr_last);
    end
  end

  // snapshot of the grid, then walk the rows
  always_ff @(posedge clk) begin
    if (start_mat_mul && cnt == latch_at) begin
      sums_q <= sums;
      wr_row <= '0;
    end else if (wr_en) begin
      wr_row <= wr_row + 1'b1;
    end
  end

  // pack the current row
  always_comb begin
    for (int j = 0; j < array_size; j++) begin
      row_word.lanes[j] = sums_q[wr_row*array_size+j];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      res_mem[addr_width'(wr_row)] <= row_word.flat;
    end
  end

  // level, holds with start and drops one cycle after it
  always_ff @(posedge clk) begin
    if (reset) begin
      done_mat_mul <= 1'b0;
    end else begin
      done_mat_mul <= start_mat_mul && (cnt == done_at);
    end
  end

  // host read, memory stage
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_word <= res_mem[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= rd_en;
    end
  end

  // output stage, holds between reads
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_pend) begin
      rd_data <= rd_word;
    end
  end

endmodule

`default_nettype wire

// File: hdl/systolic_array.sv
`default_nettype none

module systolic_array
  import matmul_pkg::*;
(
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                acc_clear,
  // lane i feeds row i from the west
  input  wire mem_word_u                     a_lanes,
  // lane j feeds column j from the north
  input  wire mem_word_u                     b_lanes,
  // cell (i,j) at index i*array_size+j
  output elem_t [array_size*array_size-1:0]  sums
);

  // a_link[i][j] enters cell (i,j), last column leaves the grid
  elem_t a_link   [array_size][array_size+1];
  // b_link[i][j] enters cell (i,j), last row leaves the grid
  elem_t b_link   [array_size+1][array_size];
  elem_t acc_grid [array_size][array_size];

  generate
    // west and north edges straight from the banks
    for (genvar e = 0; e < array_size; e++) begin : g_edge
      assign a_link[e][0] = a_lanes.lanes[e];
      assign b_link[0][e] = b_lanes.lanes[e];
    end

    for (genvar i = 0; i < array_size; i++) begin : g_row
      for (genvar j = 0; j < array_size; j++) begin : g_col
        processing_element u_pe (
          .clk       (clk),
          .reset     (reset),
          .acc_clear (acc_clear),
          .in_a      (a_link[i][j]),
          .in_b      (b_link[i][j]),
          .out_a     (a_link[i][j+1]),
          .out_b     (b_link[i+1][j]),
          .acc       (acc_grid[i][j])
        );
      end
    end
  endgenerate

  // gather accumulators, row major
  always_comb begin
    for (int i = 0; i < array_size; i++) begin
      for (int j = 0; j < array_size; j++) begin
        sums[i*array_size+j] = acc_grid[i][j];
      end
    end
  end

endmodule

`default_nettype wire

// File: test/matmul_tb.sv
`default_nettype none

module matmul_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n            = 4;
  localparam int dw           = 8;
  localparam int clk_period   = 100;
  localparam int reset_cycles = 4;
  // cycles allowed from start to done
  localparam int done_timeout = 40;
  localparam int n_runs       = 4;
  // load both banks, compute, hold, read every row
  localparam int run_cycles   = 2 * n + 1 + done_timeout + 5 + 4 * n;
  localparam int watchdog_ns  = (n_runs * (run_cycles + 50) + reset_cycles + 4) * clk_period;

  logic            clk;
  logic            reset;
  logic            we_a;
  logic            we_b;
  logic [3:0]      addr;
  logic [n*dw-1:0] wr_data;
  logic            start_mat_mul;
  logic            rd_en;
  logic [3:0]      rd_addr;
  logic [n*dw-1:0] rd_data;
  logic            done_mat_mul;

  // operands and expected result, [row][col]
  logic signed [dw-1:0] a_mat [n][n];
  logic signed [dw-1:0] b_mat [n][n];
  logic signed [dw-1:0] c_exp [n][n];

  logic [31:0] lfsr = 32'd98850;
  int value_errors    = 0;
  int protocol_errors = 0;

  matmul_top i_dut (
    .clk           (clk),
    .reset         (reset),
    .we_a          (we_a),
    .we_b          (we_b),
    .addr          (addr),
    .wr_data       (wr_data),
    .start_mat_mul (start_mat_mul),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .done_mat_mul  (done_mat_mul)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // done is a level that follows start
  assert property (@(posedge clk) disable iff (reset)
    start_mat_mul && done_mat_mul |=> done_mat_mul)
  else begin
    protocol_errors++;
    $display("done_mat_mul dropped at %0t while start_mat_mul was still held", $time);
  end

  // one cycle after start falls, done is gone
  assert property (@(posedge clk) disable iff (reset)
    $fell(start_mat_mul) |=> !done_mat_mul)
  else begin
    protocol_errors++;
    $display("done_mat_mul still high at %0t, one cycle after start_mat_mul fell", $time);
  end

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ 32'h8020_0003;
    end
    return s;
  endfunction

  // one lfsr step per bit taken
  task automatic random_byte(output logic [dw-1:0] v);
    v = '0;
    for (int b = 0; b < dw; b++) begin
      lfsr = galois_step(lfsr);
      v    = {v[dw-2:0], lfsr[0]};
    end
  endtask

  task automatic fill_random();
    logic [dw-1:0] v;
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        random_byte(v);
        a_mat[i][j] = v;
        random_byte(v);
        b_mat[i][j] = v;
      end
    end
  endtask

  // product clamped to int8, sum wraps at 8 bits
  task automatic compute_reference();
    int prod;
    logic signed [dw-1:0] acc;
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        acc = '0;
        for (int k = 0; k < n; k++) begin
          prod = int'(a_mat[i][k]) * int'(b_mat[k][j]);
          if (prod > 127) begin
            prod = 127;
          end else if (prod < -128) begin
            prod = -128;
          end
          acc = acc + prod[dw-1:0];
        end
        c_exp[i][j] = acc;
      end
    end
  endtask

  // word t of A is column t
  function automatic logic [n*dw-1:0] a_column_word(input int t);
    logic [n*dw-1:0] w;
    for (int i = 0; i < n; i++) begin
      w[i*dw +: dw] = a_mat[i][t];
    end
    return w;
  endfunction

  // word t of B is row t
  function automatic logic [n*dw-1:0] b_row_word(input int t);
    logic [n*dw-1:0] w;
    for (int j = 0; j < n; j++) begin
      w[j*dw +: dw] = b_mat[t][j];
    end
    return w;
  endfunction

  function automatic logic [n*dw-1:0] expected_row(input int r);
    logic [n*dw-1:0] w;
    for (int j = 0; j < n; j++) begin
      w[j*dw +: dw] = c_exp[r][j];
    end
    return w;
  endfunction

  task automatic load_operands();
    for (int t = 0; t < n; t++) begin
      @(negedge clk);
      we_a    = 1'b1;
      addr    = 4'(t);
      wr_data = a_column_word(t);
    end
    for (int t = 0; t < n; t++) begin
      @(negedge clk);
      we_a    = 1'b0;
      we_b    = 1'b1;
      addr    = 4'(t);
      wr_data = b_row_word(t);
    end
    @(negedge clk);
    we_b = 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!done_mat_mul && cycles < done_timeout) begin
      @(negedge clk);
      cycles++;
    end
    assert (done_mat_mul) else begin
      protocol_errors++;
      $display("done_mat_mul never arrived within %0d cycles of start", done_timeout);
    end
  endtask

  // row shows up two edges after rd_en, then holds
  task automatic read_row(input int r);
    logic [n*dw-1:0] prev;
    logic [n*dw-1:0] expected;
    prev     = rd_data;
    expected = expected_row(r);
    rd_en    = 1'b1;
    rd_addr  = 4'(r);
    @(negedge clk);
    rd_en   = 1'b0;
    // unwritten row, only a held output keeps row r
    rd_addr = 4'(n + r);
    assert (rd_data == prev) else begin
      protocol_errors++;
      $display("rd_data changed only one edge after the read of row %0d", r);
    end
    @(negedge clk);
    assert (rd_data == expected) else begin
      value_errors++;
      $display("** Error at %0t: row %0d expected %h actual %h", $time, r, expected, rd_data);
    end
    repeat (2) @(negedge clk);
    assert (rd_data == expected) else begin
      protocol_errors++;
      $display("rd_data did not hold row %0d while rd_en was low", r);
    end
  endtask

  task automatic run_matmul();
    load_operands();
    @(negedge clk);
    start_mat_mul = 1'b1;
    wait_done();
    // hold start a while, done must stay up
    repeat (3) @(negedge clk);
    assert (done_mat_mul) else begin
      protocol_errors++;
      $display("done_mat_mul was low while start_mat_mul was held");
    end
    start_mat_mul = 1'b0;
    @(negedge clk);
    assert (!done_mat_mul) else begin
      protocol_errors++;
      $display("done_mat_mul did not drop one cycle after start_mat_mul fell");
    end
    for (int r = 0; r < n; r++) begin
      read_row(r);
    end
  endtask

  // hard stop if something hangs
  initial begin
    #(watchdog_ns);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    reset         = 1'b1;
    we_a          = 1'b0;
    we_b          = 1'b0;
    addr          = '0;
    wr_data       = '0;
    start_mat_mul = 1'b0;
    rd_en         = 1'b0;
    rd_addr       = '0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // idle outputs before any start
    @(negedge clk);
    assert (!done_mat_mul && rd_data == '0) else begin
      protocol_errors++;
      $display("done_mat_mul or rd_data not zero after reset");
    end

    // identity B, so C equals A
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        a_mat[i][j] = 8'(i * n + j + 1);
        b_mat[i][j] = (i == j) ? 8'sd1 : 8'sd0;
      end
    end
    compute_reference();
    run_matmul();

    // random signed operands, wrapping sums
    fill_random();
    compute_reference();
    run_matmul();

    // every product saturates to 127
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        a_mat[i][j] = -8'sd128;
        b_mat[i][j] = -8'sd128;
      end
    end
    compute_reference();
    run_matmul();

    // fresh operands after a run, stale sums would show here
    fill_random();
    compute_reference();
    run_matmul();

    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hdl/matmul_pkg.sv
hdl/operand_bank.sv
hdl/processing_element.sv
hdl/systolic_array.sv
hdl/result_drain.sv
hdl/matmul_top.sv
test/matmul_tb.sv
